// File: pulp_lite.f
verilog/soc_map_pkg.sv
verilog/soc_txn_pkg.sv
verilog/soc_decode.sv
verilog/soc_execute.sv
verilog/soc_result.sv
verilog/pulp_lite.sv
sim/pulp_lite_properties.sv
sim/pulp_lite_tb.sv

// File: Makefile
# Verilator flow for pulp_lite

TOP = pulp_lite_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f pulp_lite.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f pulp_lite.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

// File: sim/pulp_lite_tb.sv
// --------------------------------------
// pulp_lite testbench: directed table and
// random L2 stream against a local model
// --------------------------------------

`timescale 1ns/10ps

module pulp_lite_tb;

  import soc_map_pkg::*;
  import soc_txn_pkg::*;

  localparam int unsigned L2_WORDS   = 256;
  localparam int unsigned N_CLUSTERS = 4;
  localparam int RESET_CYCLES   = 8;
  localparam int N_ENTRIES      = 26;
  localparam int N_RANDOM       = 64;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_ENTRIES + N_RANDOM + 20;
  localparam int DRAIN_LIMIT    = 6;
  // random stream works in its own 8-word window
  localparam int RAND_BASE      = 128;
  localparam addr_t FETCH_ADDR  = PERIPH_BASE_ADDR + FETCH_EN_OFFSET;

  logic                  clk_i;
  logic                  reset_i;
  logic                  req_valid_i;
  addr_t                 req_addr_i;
  op_e                   req_op_i;
  word_t                 req_wdata_i;
  logic                  rsp_valid_o;
  word_t                 rsp_rdata_o;
  logic                  rsp_error_o;
  logic [N_CLUSTERS-1:0] cl_fetch_en_o;

  // directed table
  op_e   tbl_op    [N_ENTRIES];
  addr_t tbl_addr  [N_ENTRIES];
  word_t tbl_wdata [N_ENTRIES];
  word_t tbl_data  [N_ENTRIES];
  logic  tbl_err   [N_ENTRIES];

  // responses still owed by the DUT, oldest first
  word_t                 exp_data_q[$];
  logic                  exp_err_q[$];
  logic                  exp_fen_chk_q[$];
  logic [N_CLUSTERS-1:0] exp_fen_q[$];
  int                    exp_tag_q[$];

  // L2 model for the random window
  word_t model_mem     [8];
  bit    model_written [8];

  integer seed;
  int     cycle_count;
  int     check_count;
  int     rsp_count;
  int     error_count;

  pulp_lite #(
    .L2_WORDS   (L2_WORDS),
    .N_CLUSTERS (N_CLUSTERS)
  ) i_pulp_lite (
    .clk_i,
    .reset_i,
    .req_valid_i,
    .req_addr_i,
    .req_op_i,
    .req_wdata_i,
    .rsp_valid_o,
    .rsp_rdata_o,
    .rsp_error_o,
    .cl_fetch_en_o
  );

  always #50 clk_i = ~clk_i;

  task automatic set_entry(input int idx, input op_e op, input addr_t addr,
                           input word_t wdata, input word_t data, input logic err);
    tbl_op[idx]    = op;
    tbl_addr[idx]  = addr;
    tbl_wdata[idx] = wdata;
    tbl_data[idx]  = data;
    tbl_err[idx]   = err;
  endtask

  task automatic fill_table();
    set_entry(0,  OP_STORE,    L2_BASE_ADDR,         32'hDEAD_BEEF, 32'h0, 1'b0);
    set_entry(1,  OP_LOAD,     L2_BASE_ADDR,         32'h0,         32'hDEAD_BEEF, 1'b0);
    set_entry(2,  OP_STORE,    L2_BASE_ADDR + 32'h4, 32'h0000_0010, 32'h0, 1'b0);
    set_entry(3,  OP_AMO_SWAP, L2_BASE_ADDR + 32'h4, 32'h0000_0020, 32'h0000_0010, 1'b0);
    set_entry(4,  OP_AMO_ADD,  L2_BASE_ADDR + 32'h4, 32'h0000_0005, 32'h0000_0020, 1'b0);
    set_entry(5,  OP_LOAD,     L2_BASE_ADDR + 32'h4, 32'h0,         32'h0000_0025, 1'b0);
    set_entry(6,  OP_STORE,    L2_BASE_ADDR + 32'h8, 32'hF0F0_F0F0, 32'h0, 1'b0);
    set_entry(7,  OP_AMO_AND,  L2_BASE_ADDR + 32'h8, 32'hFF00_FF00, 32'hF0F0_F0F0, 1'b0);
    set_entry(8,  OP_AMO_OR,   L2_BASE_ADDR + 32'h8, 32'h0000_000F, 32'hF000_F000, 1'b0);
    set_entry(9,  OP_LOAD,     L2_BASE_ADDR + 32'h8, 32'h0,         32'hF000_F00F, 1'b0);
    set_entry(10, OP_STORE,    L2_BASE_ADDR + 32'hC, 32'h8000_0000, 32'h0, 1'b0);
    // unsigned compare, 0x8000_0000 wins over 0x7FFF_FFFF
    set_entry(11, OP_AMO_MAXU, L2_BASE_ADDR + 32'hC, 32'h7FFF_FFFF, 32'h8000_0000, 1'b0);
    set_entry(12, OP_AMO_MAXU, L2_BASE_ADDR + 32'hC, 32'hFFFF_FFF0, 32'h8000_0000, 1'b0);
    set_entry(13, OP_LOAD,     L2_BASE_ADDR + 32'hC, 32'h0,         32'hFFFF_FFF0, 1'b0);
    set_entry(14, OP_STORE,    FETCH_ADDR,           32'hFFFF_FFF5, 32'h0, 1'b0);
    set_entry(15, OP_LOAD,     FETCH_ADDR,           32'h0,         32'h0000_0005, 1'b0);
    // misaligned and past-the-end both alias word 0, which must stay intact
    set_entry(16, OP_STORE,    L2_BASE_ADDR + 32'h2, 32'h1234_5678, 32'h0, 1'b1);
    set_entry(17, OP_LOAD,     L2_BASE_ADDR,         32'h0,         32'hDEAD_BEEF, 1'b0);
    set_entry(18, OP_STORE,    L2_BASE_ADDR + addr_t'(4 * L2_WORDS), 32'h1111_1111,
              32'h0, 1'b1);
    set_entry(19, OP_LOAD,     L2_BASE_ADDR,         32'h0,         32'hDEAD_BEEF, 1'b0);
    set_entry(20, OP_LOAD,     32'h2000_0000,        32'h0,         32'h0, 1'b1);
    set_entry(21, OP_STORE,    FETCH_ADDR + 32'h4,   32'h0000_000F, 32'h0, 1'b1);
    set_entry(22, OP_AMO_ADD,  FETCH_ADDR,           32'h0000_0001, 32'h0, 1'b1);
    set_entry(23, OP_LOAD,     FETCH_ADDR,           32'h0,         32'h0000_0005, 1'b0);
    set_entry(24, OP_STORE,    FETCH_ADDR,           32'h0000_000A, 32'h0, 1'b0);
    set_entry(25, OP_LOAD,     FETCH_ADDR,           32'h0,         32'h0000_000A, 1'b0);
  endtask

  function automatic word_t amo_result(input op_e op, input word_t old_w, input word_t wd);
    case (op)
      OP_AMO_SWAP: return wd;
      OP_AMO_ADD:  return old_w + wd;
      OP_AMO_AND:  return old_w & wd;
      OP_AMO_OR:   return old_w | wd;
      OP_AMO_MAXU: return (old_w > wd) ? old_w : wd;
      default:     return old_w;
    endcase
  endfunction

  task automatic issue_req(input op_e op, input addr_t addr, input word_t wdata);
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_addr_i  <= addr;
    req_op_i    <= op;
    req_wdata_i <= wdata;
  endtask

  task automatic go_idle();
    @(posedge clk_i);
    req_valid_i <= 1'b0;
  endtask

  task automatic expect_rsp(input word_t data, input logic err, input logic fen_chk,
                            input logic [N_CLUSTERS-1:0] fen, input int tag);
    exp_data_q.push_back(data);
    exp_err_q.push_back(err);
    exp_fen_chk_q.push_back(fen_chk);
    exp_fen_q.push_back(fen);
    exp_tag_q.push_back(tag);
  endtask

  task automatic wait_for_drain();
    int waited;
    waited = 0;
    while (exp_data_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    if (exp_data_q.size() != 0) begin
      error_count++;
      $display("missing response: %0d request(s) never answered at %0t",
               exp_data_q.size(), $time);
      exp_data_q.delete();
      exp_err_q.delete();
      exp_fen_chk_q.delete();
      exp_fen_q.delete();
      exp_tag_q.delete();
    end
  endtask

  // outputs are sampled half a cycle after the edge
  always @(negedge clk_i) begin : check_response
    word_t                 e_data;
    logic                  e_err;
    logic                  e_fen_chk;
    logic [N_CLUSTERS-1:0] e_fen;
    int                    e_tag;
    bit                    ok;
    if (reset_i) begin
      if (rsp_valid_o === 1'b1) begin
        error_count++;
        $display("response seen while reset is asserted at %0t", $time);
      end
    end else if (rsp_valid_o === 1'b1) begin
      rsp_count++;
      if (exp_data_q.size() == 0) begin
        error_count++;
        $display("response arrived at %0t with no request outstanding", $time);
      end else begin
        e_data    = exp_data_q.pop_front();
        e_err     = exp_err_q.pop_front();
        e_fen_chk = exp_fen_chk_q.pop_front();
        e_fen     = exp_fen_q.pop_front();
        e_tag     = exp_tag_q.pop_front();
        ok        = 1'b1;
        check_count++;
        if (rsp_rdata_o !== e_data) begin
          ok = 1'b0;
          error_count++;
          $display("Fail %0t: rdata %h, expected %h", $time, rsp_rdata_o, e_data);
        end
        if (rsp_error_o !== e_err) begin
          ok = 1'b0;
          error_count++;
          $display("Fail %0t: error flag %b, expected %b", $time, rsp_error_o, e_err);
        end
        if (e_fen_chk && cl_fetch_en_o !== e_fen) begin
          ok = 1'b0;
          error_count++;
          $display("Fail %0t: fetch enable %h, expected %h", $time, cl_fetch_en_o, e_fen);
        end
        if (e_tag >= 0) begin
          $display("entry %0d: %s", e_tag, ok ? "ok" : "failed");
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cycle_count);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    int    slot;
    logic  [31:0] rnd;
    op_e   op;
    word_t wdata;
    word_t exp_w;
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    req_op_i    = OP_LOAD;
    req_wdata_i = '0;
    seed        = 91441;
    cycle_count = 0;
    check_count = 0;
    rsp_count   = 0;
    error_count = 0;
    fill_table();

    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    if (cl_fetch_en_o !== '0) begin
      error_count++;
      $display("Fail %0t: fetch enable %h after reset", $time, cl_fetch_en_o);
    end

    for (int i = 0; i < N_ENTRIES; i++) begin
      issue_req(tbl_op[i], tbl_addr[i], tbl_wdata[i]);
      expect_rsp(tbl_data[i], tbl_err[i],
                 tbl_addr[i] == FETCH_ADDR && tbl_op[i] == OP_STORE && !tbl_err[i],
                 tbl_wdata[i][N_CLUSTERS-1:0], i);
    end
    go_idle();
    wait_for_drain();
    $display("table phase: %0d entries, %0d errors so far", N_ENTRIES, error_count);

    // back-to-back L2 traffic, unwritten words get a store first
    for (int n = 0; n < N_RANDOM; n++) begin
      rnd   = $random(seed);
      slot  = int'(rnd[2:0]);
      op    = op_e'(rnd[10:8] % 3'd7);
      wdata = $random(seed);
      if (!model_written[slot]) begin
        op = OP_STORE;
      end
      exp_w = model_mem[slot];
      if (op == OP_STORE) begin
        exp_w               = '0;
        model_mem[slot]     = wdata;
        model_written[slot] = 1'b1;
      end else if (op != OP_LOAD) begin
        model_mem[slot] = amo_result(op, exp_w, wdata);
      end
      issue_req(op, L2_BASE_ADDR + addr_t'((RAND_BASE + slot) * 4), wdata);
      expect_rsp(exp_w, 1'b0, 1'b0, '0, -1);
    end
    go_idle();
    wait_for_drain();
    $display("random phase: %0d requests, %0d errors so far", N_RANDOM, error_count);

    $display("responses: %0d, checks: %0d, errors: %0d", rsp_count, check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: sim/pulp_lite_properties.sv
// --------------------------------------
// pulp_lite checks: response timing and
// quiet error data
// --------------------------------------

`timescale 1ns/10ps

module pulp_lite_properties (
  input logic                clk_i,
  input logic                reset_i,
  input logic                req_valid_i,
  input logic                rsp_valid_i,
  input soc_txn_pkg::word_t  rsp_rdata_i,
  input logic                rsp_error_i
);

  // decode, execute and result each add one register
  rsp_latency_a: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_i == $past(req_valid_i, 3))
    else $error("response pulse does not follow its request by three cycles");

  // error responses carry no data
  error_data_a: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_error_i |-> (rsp_rdata_i == '0))
    else $error("error response with nonzero read data");

  reset_quiet_a: assert property (@(posedge clk_i)
    reset_i |=> !rsp_valid_i)
    else $error("response valid while in reset");

endmodule

bind pulp_lite pulp_lite_properties i_pulp_lite_properties (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .req_valid_i (req_valid_i),
  .rsp_valid_i (rsp_valid_o),
  .rsp_rdata_i (rsp_rdata_o),
  .rsp_error_i (rsp_error_o)
);

// File: verilog/pulp_lite.sv
// --------------------------------------
// pulp_lite: three-stage memory subsystem
// with L2 scratch and cluster control
// --------------------------------------

`timescale 1ns/10ps

module pulp_lite #(
  parameter int unsigned L2_WORDS   = 256,   // power of two
  parameter int unsigned N_CLUSTERS = 4      // 1 to 32
) (
  input  logic                  clk_i,
  input  logic                  reset_i,

  // requester
  input  logic                  req_valid_i,
  input  soc_map_pkg::addr_t    req_addr_i,
  input  soc_txn_pkg::op_e      req_op_i,
  input  soc_txn_pkg::word_t    req_wdata_i,

  // response
  output logic                  rsp_valid_o,
  output soc_txn_pkg::word_t    rsp_rdata_o,
  output logic                  rsp_error_o,

  // cluster control
  output logic [N_CLUSTERS-1:0] cl_fetch_en_o
);

  import soc_map_pkg::*;
  import soc_txn_pkg::*;

  localparam int unsigned IDX_W = $clog2(L2_WORDS);

  // decode to execute
  logic             dec_valid;
  region_e          dec_region;
  logic [IDX_W-1:0] dec_index;
  op_e              dec_op;
  word_t            dec_wdata;

  // execute to result
  logic             exe_valid;
  logic             exe_error;
  word_t            exe_rdata;

  soc_decode #(
    .L2_WORDS (L2_WORDS)
  ) i_soc_decode (
    .clk_i,
    .reset_i,
    .req_valid_i,
    .req_addr_i,
    .req_op_i,
    .req_wdata_i,
    .dec_valid_o  (dec_valid),
    .dec_region_o (dec_region),
    .dec_index_o  (dec_index),
    .dec_op_o     (dec_op),
    .dec_wdata_o  (dec_wdata)
  );

  soc_execute #(
    .L2_WORDS   (L2_WORDS),
    .N_CLUSTERS (N_CLUSTERS)
  ) i_soc_execute (
    .clk_i,
    .reset_i,
    .dec_valid_i  (dec_valid),
    .dec_region_i (dec_region),
    .dec_index_i  (dec_index),
    .dec_op_i     (dec_op),
    .dec_wdata_i  (dec_wdata),
    .exe_valid_o  (exe_valid),
    .exe_error_o  (exe_error),
    .exe_rdata_o  (exe_rdata),
    .cl_fetch_en_o
  );

  soc_result i_soc_result (
    .clk_i,
    .reset_i,
    .exe_valid_i (exe_valid),
    .exe_error_i (exe_error),
    .exe_rdata_i (exe_rdata),
    .rsp_valid_o,
    .rsp_rdata_o,
    .rsp_error_o
  );

endmodule

// File: verilog/soc_result.sv
// --------------------------------------
// Result stage: registers the response
// --------------------------------------

`timescale 1ns/10ps

module soc_result (
  input  logic                clk_i,
  input  logic                reset_i,

  // from execute
  input  logic                exe_valid_i,
  input  logic                exe_error_i,
  input  soc_txn_pkg::word_t  exe_rdata_i,

  // response to the requester
  output logic                rsp_valid_o,
  output soc_txn_pkg::word_t  rsp_rdata_o,
  output logic                rsp_error_o
);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_o <= 1'b0;
      rsp_rdata_o <= '0;
      rsp_error_o <= 1'b0;
    end else begin
      rsp_valid_o <= exe_valid_i;
      // bus stays quiet between responses
      if (exe_valid_i) begin
        rsp_rdata_o <= exe_rdata_i;
        rsp_error_o <= exe_error_i;
      end else begin
        rsp_rdata_o <= '0;
        rsp_error_o <= 1'b0;
      end
    end
  end

endmodule

// File: verilog/soc_execute.sv
// --------------------------------------
// Execute stage: L2 array with atomics and
// the cluster fetch-enable register
// --------------------------------------

`timescale 1ns/10ps

module soc_execute #(
  parameter int unsigned L2_WORDS   = 256,
  parameter int unsigned N_CLUSTERS = 4
) (
  input  logic                          clk_i,
  input  logic                          reset_i,

  // decoded request
  input  logic                          dec_valid_i,
  input  soc_map_pkg::region_e          dec_region_i,
  input  logic [$clog2(L2_WORDS)-1:0]   dec_index_i,
  input  soc_txn_pkg::op_e              dec_op_i,
  input  soc_txn_pkg::word_t            dec_wdata_i,

  // result towards the response stage
  output logic                          exe_valid_o,
  output logic                          exe_error_o,
  output soc_txn_pkg::word_t            exe_rdata_o,

  // cluster control
  output logic [N_CLUSTERS-1:0]         cl_fetch_en_o
);

  import soc_map_pkg::*;
  import soc_txn_pkg::*;

  // L2 scratch memory, no reset on the contents
  word_t l2_mem [L2_WORDS];

  logic [N_CLUSTERS-1:0] fetch_en_q;

  word_t old_word;
  word_t amo_word;
  logic  is_amo;
  logic  l2_we;
  word_t l2_wdata;
  logic  fetch_en_we;
  word_t rdata_d;
  logic  error_d;

  // read side of the read-modify-write
  assign old_word = l2_mem[dec_index_i];

  // atomic arithmetic on the old word
  always_comb begin
    is_amo   = 1'b1;
    amo_word = old_word;
    case (dec_op_i)
      OP_AMO_SWAP: amo_word = dec_wdata_i;
      OP_AMO_ADD:  amo_word = old_word + dec_wdata_i;
      OP_AMO_AND:  amo_word = old_word & dec_wdata_i;
      OP_AMO_OR:   amo_word = old_word | dec_wdata_i;
      OP_AMO_MAXU: amo_word = (old_word > dec_wdata_i) ? old_word : dec_wdata_i;
      default:     is_amo   = 1'b0;
    endcase
  end

  // target selection and operation legality
  always_comb begin
    l2_we       = 1'b0;
    l2_wdata    = dec_wdata_i;
    fetch_en_we = 1'b0;
    rdata_d     = '0;
    error_d     = 1'b0;

    if (dec_valid_i) begin
      case (dec_region_i)
        REGION_L2: begin
          if (dec_op_i == OP_LOAD) begin
            rdata_d = old_word;
          end else if (dec_op_i == OP_STORE) begin
            l2_we = 1'b1;
          end else if (is_amo) begin
            // atomics hand back the old word
            l2_we    = 1'b1;
            l2_wdata = amo_word;
            rdata_d  = old_word;
          end else begin
            error_d = 1'b1;
          end
        end

        REGION_PERIPH: begin
          if (dec_op_i == OP_LOAD) begin
            rdata_d = word_t'(fetch_en_q);
          end else if (dec_op_i == OP_STORE) begin
            fetch_en_we = 1'b1;
          end else begin
            // no atomics on the peripheral
            error_d = 1'b1;
          end
        end

        default: begin
          error_d = 1'b1;
        end
      endcase
    end
  end

  // write back at the same edge, so the next access sees it
  always_ff @(posedge clk_i) begin
    if (l2_we) begin
      l2_mem[dec_index_i] <= l2_wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fetch_en_q <= '0;
    end else if (fetch_en_we) begin
      fetch_en_q <= dec_wdata_i[N_CLUSTERS-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exe_valid_o <= 1'b0;
      exe_error_o <= 1'b0;
    end else begin
      exe_valid_o <= dec_valid_i;
      exe_error_o <= error_d;
    end
  end

  // zero on error and on stores
  always_ff @(posedge clk_i) begin
    exe_rdata_o <= rdata_d;
  end

  assign cl_fetch_en_o = fetch_en_q;

endmodule

// File: verilog/soc_decode.sv
// --------------------------------------
// Decode stage: maps the request address
// onto the SoC memory map, one cycle
// --------------------------------------

`timescale 1ns/10ps

module soc_decode #(
  parameter int unsigned L2_WORDS = 256
) (
  input  logic                          clk_i,
  input  logic                          reset_i,

  // request from the requester
  input  logic                          req_valid_i,
  input  soc_map_pkg::addr_t            req_addr_i,
  input  soc_txn_pkg::op_e              req_op_i,
  input  soc_txn_pkg::word_t            req_wdata_i,

  // decoded request towards execute
  output logic                          dec_valid_o,
  output soc_map_pkg::region_e          dec_region_o,
  output logic [$clog2(L2_WORDS)-1:0]   dec_index_o,
  output soc_txn_pkg::op_e              dec_op_o,
  output soc_txn_pkg::word_t            dec_wdata_o
);

  import soc_map_pkg::*;

  localparam int unsigned IDX_W = $clog2(L2_WORDS);

  // size of the L2 window in bytes
  localparam addr_t L2_BYTES = addr_t'(L2_WORDS) << WORD_BYTE_BITS;

  addr_t      l2_offset;
  logic       aligned;
  logic       in_l2;
  logic       is_fetch_en;
  region_e    region_d;

  // an address below the base wraps to a large offset, so one compare covers both ends
  assign l2_offset   = req_addr_i - L2_BASE_ADDR;
  assign aligned     = (req_addr_i[WORD_BYTE_BITS-1:0] == '0);
  assign in_l2       = (l2_offset < L2_BYTES);
  assign is_fetch_en = (req_addr_i == (PERIPH_BASE_ADDR + FETCH_EN_OFFSET));

  always_comb begin
    if (aligned && in_l2) begin
      region_d = REGION_L2;
    end else if (is_fetch_en) begin
      region_d = REGION_PERIPH;
    end else begin
      // misaligned, past the end of L2 or unmapped
      region_d = REGION_NONE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= req_valid_i;
    end
  end

  // payload, only looked at while dec_valid_o is high
  always_ff @(posedge clk_i) begin
    dec_region_o <= region_d;
    dec_index_o  <= l2_offset[IDX_W+WORD_BYTE_BITS-1:WORD_BYTE_BITS];
    dec_op_o     <= req_op_i;
    dec_wdata_o  <= req_wdata_i;
  end

endmodule

// File: verilog/soc_txn_pkg.sv
// --------------------------------------
// Transaction encoding: operation codes
// and the data word
// --------------------------------------

package soc_txn_pkg;

  // data path width, one RISC-V word
  localparam int unsigned RISCV_WORD_WIDTH = 32;
  typedef logic [RISCV_WORD_WIDTH-1:0] word_t;

  // plain accesses first, then the atomics
  typedef enum logic [2:0] {
    OP_LOAD     = 3'd0,
    OP_STORE    = 3'd1,
    OP_AMO_SWAP = 3'd2,
    OP_AMO_ADD  = 3'd3,
    OP_AMO_AND  = 3'd4,
    OP_AMO_OR   = 3'd5,
    // unsigned maximum
    OP_AMO_MAXU = 3'd6
  } op_e;

endpackage

// File: verilog/soc_map_pkg.sv
// --------------------------------------
// SoC memory map: base addresses, region
// classes and address field widths
// --------------------------------------

package soc_map_pkg;

  // system byte address
  localparam int unsigned ADDR_WIDTH = 32;
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // byte offset bits inside one 32-bit word
  localparam int unsigned WORD_BYTE_BITS = 2;

  // L2 scratch memory
  localparam addr_t L2_BASE_ADDR = 32'h1C00_0000;

  // peripheral block, cluster control
  localparam addr_t PERIPH_BASE_ADDR = 32'h1A10_0000;
  localparam addr_t FETCH_EN_OFFSET  = 32'h0000_0000;

  // target class after decode
  typedef enum logic [1:0] {
    REGION_L2     = 2'd0,
    REGION_PERIPH = 2'd1,
    REGION_NONE   = 2'd2
  } region_e;

endpackage
